/* design/mem_sub_params.svh */
`ifndef MEM_SUB_PARAMS_SVH
`define MEM_SUB_PARAMS_SVH

// Datapath widths
`define WORD_SIZE 32
`define ADDR_SIZE 32
`define REG_SIZE 5

// Direct-mapped data cache geometry
`define DCACHE_LINES 4
// Index sits at address bits 5:4
`define DCACHE_INDEX_SIZE 2
`define DCACHE_BYTE_SIZE 4
`define DCACHE_LANE_SIZE 128

// Pending stores, power of two
`define SB_ENTRIES 2

`endif

/* design/mem_sub_pkg.sv */
`include "mem_sub_params.svh"

package mem_sub_pkg;

    // Ordered by width so sizes compare numerically
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } memop_size_e;

    localparam int LANE_WORDS = `DCACHE_LANE_SIZE / `WORD_SIZE;
    localparam int LANE_BYTES = `DCACHE_LANE_SIZE / 8;

    // One cache lane seen as words or as bytes
    typedef union packed {
        logic [LANE_WORDS-1:0][`WORD_SIZE-1:0] words;
        logic [LANE_BYTES-1:0][7:0]            bytes;
    } dcache_lane_u;

endpackage

/* design/dcache_data.sv */
`include "mem_sub_params.svh"

module dcache_data import mem_sub_pkg::*; (
    input  logic                          clk_i,
    input  logic                          rd_data_i,
    input  logic                          wr_data_i,
    input  logic                          mmu_wr_data_i,
    input  logic [`DCACHE_INDEX_SIZE-1:0] index_i,
    input  logic [`DCACHE_BYTE_SIZE-1:0]  byte_i,
    input  memop_size_e                   memop_data_type_load_i,
    input  memop_size_e                   memop_data_type_store_i,
    input  logic [`WORD_SIZE-1:0]         data_i,
    input  logic [`DCACHE_LANE_SIZE-1:0]  mmu_data_i,
    output logic [`WORD_SIZE-1:0]         data_o
);

    dcache_lane_u lanes [`DCACHE_LINES];

    dcache_lane_u            rd_lane;
    logic [`WORD_SIZE-1:0]   rd_word;
    logic [4:0]              rd_shift;
    dcache_lane_u            wr_lane;
    logic [`WORD_SIZE-1:0]   wr_word;
    logic [LANE_BYTES-1:0]   byte_en;

    assign rd_lane = lanes[index_i];
    assign rd_word = rd_lane.words[byte_i[3:2]];

    // Addressed byte or half ends up at bit 0
    always_comb begin
        unique case (memop_data_type_load_i)
            BYTE:    rd_shift = {byte_i[1:0], 3'b000};
            HALF:    rd_shift = {byte_i[1], 4'b0000};
            default: rd_shift = '0;
        endcase
    end

    assign data_o = rd_word >> rd_shift;

    // Store data replicated across the lane, enables pick the bytes
    assign wr_word       = data_i << {byte_i[1:0], 3'b000};
    assign wr_lane.words = {LANE_WORDS{wr_word}};

    always_comb begin
        unique case (memop_data_type_store_i)
            BYTE:    byte_en = LANE_BYTES'(16'h0001) << byte_i;
            HALF:    byte_en = LANE_BYTES'(16'h0003) << byte_i;
            default: byte_en = LANE_BYTES'(16'h000f) << byte_i;
        endcase
    end

    // Line fill wins over a drained store
    always_ff @(posedge clk_i) begin
        if (mmu_wr_data_i) begin
            lanes[index_i] <= dcache_lane_u'(mmu_data_i);
        end else if (wr_data_i) begin
            for (int b = 0; b < LANE_BYTES; b++) begin
                if (byte_en[b]) begin
                    lanes[index_i].bytes[b] <= wr_lane.bytes[b];
                end
            end
        end
    end

    // The store buffer only drains in cycles without a load
    a_no_load_during_drain: assert property (
        @(posedge clk_i) !(rd_data_i && wr_data_i)
    );

endmodule

/* design/store_buffer.sv */
`include "mem_sub_params.svh"

module store_buffer import mem_sub_pkg::*; (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  wr_i,
    input  logic                  rd_i,
    input  logic [`ADDR_SIZE-1:0] addr_i,
    input  memop_size_e           type_i,
    input  logic [`WORD_SIZE-1:0] data_i,
    input  logic                  fill_busy_i,
    output logic                  hit_o,
    output logic [`WORD_SIZE-1:0] load_data_o,
    output logic                  flush_o,
    output logic [`ADDR_SIZE-1:0] flush_addr_o,
    output logic [`WORD_SIZE-1:0] flush_data_o,
    output memop_size_e           flush_type_o,
    output logic                  empty_o
);

    localparam int PTR_W   = $clog2(`SB_ENTRIES);
    localparam int COUNT_W = $clog2(`SB_ENTRIES + 1);

    logic [`ADDR_SIZE-1:0] addr_q [`SB_ENTRIES];
    logic [`WORD_SIZE-1:0] data_q [`SB_ENTRIES];
    memop_size_e           type_q [`SB_ENTRIES];

    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [COUNT_W-1:0] count_q;
    logic [COUNT_W-1:0] count_next;
    logic               full;
    logic               match;
    logic [`WORD_SIZE-1:0] match_data;

    assign full = (count_q == COUNT_W'(`SB_ENTRIES));

    // Drain when idle, or to make room for an incoming store
    assign flush_o = (count_q != '0) && !fill_busy_i &&
                     ((!wr_i && !rd_i) || (wr_i && full));

    assign flush_addr_o = addr_q[rd_ptr_q];
    assign flush_data_o = data_q[rd_ptr_q];
    assign flush_type_o = type_q[rd_ptr_q];

    // Walk oldest to youngest so the youngest match sticks
    always_comb begin
        logic [PTR_W-1:0] slot;
        match      = 1'b0;
        match_data = '0;
        for (int i = 0; i < `SB_ENTRIES; i++) begin
            slot = rd_ptr_q + PTR_W'(i);
            if (COUNT_W'(i) < count_q && addr_q[slot] == addr_i &&
                type_q[slot] >= type_i) begin
                match      = 1'b1;
                match_data = data_q[slot];
            end
        end
    end

    assign hit_o       = rd_i && match;
    assign load_data_o = match_data;

    always_comb begin
        count_next = count_q;
        if (wr_i && !flush_o) begin
            count_next = count_q + 1'b1;
        end else if (flush_o && !wr_i) begin
            count_next = count_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_i) begin
            addr_q[wr_ptr_q] <= addr_i;
            data_q[wr_ptr_q] <= data_i;
            type_q[wr_ptr_q] <= type_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            empty_o  <= 1'b1;
        end else begin
            if (wr_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (flush_o) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_next;
            empty_o <= (count_next == '0);
        end
    end

    a_no_overflow: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) count_q <= COUNT_W'(`SB_ENTRIES)
    );

    // A full buffer cannot drain while the memory side fills a lane
    a_no_store_when_stuck: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) (wr_i && full) |-> !fill_busy_i
    );

endmodule

/* design/mem_stage.sv */
`include "mem_sub_params.svh"

module mem_stage import mem_sub_pkg::*; (
    input  logic                          clk_i,
    input  logic                          arst_n_i,
    input  logic [`ADDR_SIZE-1:0]         memop_addr_i,
    input  logic                          memop_rd_i,
    input  logic                          memop_wr_i,
    input  memop_size_e                   memop_type_i,
    input  logic                          memop_sign_ext_i,
    input  logic                          rf_we_i,
    input  logic [`REG_SIZE-1:0]          rf_waddr_i,
    input  logic                          tkbr_i,
    input  logic [`WORD_SIZE-1:0]         new_pc_i,
    input  logic                          sb_hit_i,
    input  logic [`WORD_SIZE-1:0]         sb_load_data_i,
    input  logic                          sb_flush_i,
    input  logic [`ADDR_SIZE-1:0]         sb_flush_addr_i,
    input  logic [`WORD_SIZE-1:0]         sb_flush_data_i,
    input  memop_size_e                   sb_flush_type_i,
    input  logic                          mmu_data_rdy_i,
    input  logic [`DCACHE_LANE_SIZE-1:0]  mmu_data_i,
    input  logic [`DCACHE_INDEX_SIZE-1:0] mmu_lru_index_i,
    output logic [`WORD_SIZE-1:0]         op_res_o,
    output logic                          rf_we_o,
    output logic [`REG_SIZE-1:0]          rf_waddr_o,
    output logic                          tkbr_o,
    output logic [`WORD_SIZE-1:0]         new_pc_o
);

    logic [`DCACHE_INDEX_SIZE-1:0] cache_index;
    logic [`DCACHE_BYTE_SIZE-1:0]  cache_byte;
    logic [`WORD_SIZE-1:0]         cache_data;
    logic [`WORD_SIZE-1:0]         raw_data;
    logic [`WORD_SIZE-1:0]         ext_data;

    always_comb begin
        if (mmu_data_rdy_i) begin
            cache_index = mmu_lru_index_i;
        end else if (sb_flush_i) begin
            cache_index = sb_flush_addr_i[`DCACHE_BYTE_SIZE +: `DCACHE_INDEX_SIZE];
        end else begin
            cache_index = memop_addr_i[`DCACHE_BYTE_SIZE +: `DCACHE_INDEX_SIZE];
        end
    end

    assign cache_byte = sb_flush_i ? sb_flush_addr_i[`DCACHE_BYTE_SIZE-1:0]
                                   : memop_addr_i[`DCACHE_BYTE_SIZE-1:0];

    // Cache writes only come from fills and store buffer drains
    dcache_data u_dcache_data (
        .clk_i                   (clk_i),
        .rd_data_i               (memop_rd_i),
        .wr_data_i               (sb_flush_i),
        .mmu_wr_data_i           (mmu_data_rdy_i),
        .index_i                 (cache_index),
        .byte_i                  (cache_byte),
        .memop_data_type_load_i  (memop_type_i),
        .memop_data_type_store_i (sb_flush_type_i),
        .data_i                  (sb_flush_data_i),
        .mmu_data_i              (mmu_data_i),
        .data_o                  (cache_data)
    );

    // Forwarded store data is newer than the cache
    assign raw_data = sb_hit_i ? sb_load_data_i : cache_data;

    always_comb begin
        unique case (memop_type_i)
            BYTE:    ext_data = {{24{memop_sign_ext_i & raw_data[7]}}, raw_data[7:0]};
            HALF:    ext_data = {{16{memop_sign_ext_i & raw_data[15]}}, raw_data[15:0]};
            default: ext_data = raw_data;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            op_res_o   <= '0;
            rf_we_o    <= 1'b0;
            rf_waddr_o <= '0;
            tkbr_o     <= 1'b0;
            new_pc_o   <= '0;
        end else begin
            op_res_o   <= memop_rd_i ? ext_data : memop_addr_i;
            rf_we_o    <= rf_we_i;
            rf_waddr_o <= rf_waddr_i;
            tkbr_o     <= tkbr_i;
            new_pc_o   <= new_pc_i;
        end
    end

    a_one_memop: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) !(memop_rd_i && memop_wr_i)
    );

endmodule

/* design/mem_subsystem_top.sv */
`include "mem_sub_params.svh"

module mem_subsystem_top import mem_sub_pkg::*; (
    input  logic                          clk_i,
    input  logic                          arst_n_i,
    input  logic                          memop_rd_i,
    input  logic                          memop_wr_i,
    input  logic [`ADDR_SIZE-1:0]         memop_addr_i,
    input  memop_size_e                   memop_type_i,
    input  logic                          memop_sign_ext_i,
    input  logic [`WORD_SIZE-1:0]         store_data_i,
    input  logic                          rf_we_i,
    input  logic [`REG_SIZE-1:0]          rf_waddr_i,
    input  logic                          tkbr_i,
    input  logic [`WORD_SIZE-1:0]         new_pc_i,
    input  logic                          mmu_data_rdy_i,
    input  logic [`DCACHE_LANE_SIZE-1:0]  mmu_data_i,
    input  logic [`DCACHE_INDEX_SIZE-1:0] mmu_lru_index_i,
    output logic [`WORD_SIZE-1:0]         op_res_o,
    output logic                          rf_we_o,
    output logic [`REG_SIZE-1:0]          rf_waddr_o,
    output logic                          tkbr_o,
    output logic [`WORD_SIZE-1:0]         new_pc_o,
    output logic                          sb_empty_o
);

    logic                  sb_hit;
    logic [`WORD_SIZE-1:0] sb_load_data;
    logic                  sb_flush;
    logic [`ADDR_SIZE-1:0] sb_flush_addr;
    logic [`WORD_SIZE-1:0] sb_flush_data;
    memop_size_e           sb_flush_type;

    store_buffer u_store_buffer (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .wr_i         (memop_wr_i),
        .rd_i         (memop_rd_i),
        .addr_i       (memop_addr_i),
        .type_i       (memop_type_i),
        .data_i       (store_data_i),
        .fill_busy_i  (mmu_data_rdy_i),
        .hit_o        (sb_hit),
        .load_data_o  (sb_load_data),
        .flush_o      (sb_flush),
        .flush_addr_o (sb_flush_addr),
        .flush_data_o (sb_flush_data),
        .flush_type_o (sb_flush_type),
        .empty_o      (sb_empty_o)
    );

    mem_stage u_mem_stage (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .memop_addr_i     (memop_addr_i),
        .memop_rd_i       (memop_rd_i),
        .memop_wr_i       (memop_wr_i),
        .memop_type_i     (memop_type_i),
        .memop_sign_ext_i (memop_sign_ext_i),
        .rf_we_i          (rf_we_i),
        .rf_waddr_i       (rf_waddr_i),
        .tkbr_i           (tkbr_i),
        .new_pc_i         (new_pc_i),
        .sb_hit_i         (sb_hit),
        .sb_load_data_i   (sb_load_data),
        .sb_flush_i       (sb_flush),
        .sb_flush_addr_i  (sb_flush_addr),
        .sb_flush_data_i  (sb_flush_data),
        .sb_flush_type_i  (sb_flush_type),
        .mmu_data_rdy_i   (mmu_data_rdy_i),
        .mmu_data_i       (mmu_data_i),
        .mmu_lru_index_i  (mmu_lru_index_i),
        .op_res_o         (op_res_o),
        .rf_we_o          (rf_we_o),
        .rf_waddr_o       (rf_waddr_o),
        .tkbr_o           (tkbr_o),
        .new_pc_o         (new_pc_o)
    );

endmodule

/* verification/mem_subsystem_tb.sv */
`include "mem_sub_params.svh"

module mem_subsystem_tb import mem_sub_pkg::*; ();

    localparam int DRAIN_LIMIT = 50;

    logic                          clk_i;
    logic                          arst_n_i;
    logic                          memop_rd_i;
    logic                          memop_wr_i;
    logic [`ADDR_SIZE-1:0]         memop_addr_i;
    memop_size_e                   memop_type_i;
    logic                          memop_sign_ext_i;
    logic [`WORD_SIZE-1:0]         store_data_i;
    logic                          rf_we_i;
    logic [`REG_SIZE-1:0]          rf_waddr_i;
    logic                          tkbr_i;
    logic [`WORD_SIZE-1:0]         new_pc_i;
    logic                          mmu_data_rdy_i;
    logic [`DCACHE_LANE_SIZE-1:0]  mmu_data_i;
    logic [`DCACHE_INDEX_SIZE-1:0] mmu_lru_index_i;
    logic [`WORD_SIZE-1:0]         op_res_o;
    logic                          rf_we_o;
    logic [`REG_SIZE-1:0]          rf_waddr_o;
    logic                          tkbr_o;
    logic [`WORD_SIZE-1:0]         new_pc_o;
    logic                          sb_empty_o;

    // Cache image in program order, buffered stores already applied
    dcache_lane_u model [`DCACHE_LINES];

    logic [31:0] rng_state;
    int          errors;
    int          checks;

    logic [`WORD_SIZE-1:0] exp_res_q [$];
    logic                  exp_we_q [$];
    logic [`REG_SIZE-1:0]  exp_waddr_q [$];
    logic                  exp_tkbr_q [$];
    logic [`WORD_SIZE-1:0] exp_pc_q [$];

    mem_subsystem_top uut (.*);

    initial begin
        clk_i = 1'b0;
        forever begin
            #20 clk_i = ~clk_i;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [7:0] model_byte(input logic [5:0] a);
        return model[a[5:4]].bytes[a[3:0]];
    endfunction

    // Little-endian load from the image, then extension by size
    function automatic logic [31:0] expected_load(input logic [5:0] a, input memop_size_e sz,
                                                  input logic sext);
        logic [31:0] w;
        w = {model_byte(a + 6'd3), model_byte(a + 6'd2), model_byte(a + 6'd1), model_byte(a)};
        case (sz)
            BYTE:    return {{24{sext & w[7]}}, w[7:0]};
            HALF:    return {{16{sext & w[15]}}, w[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic model_store(input logic [5:0] a, input memop_size_e sz, input logic [31:0] d);
        int         n;
        logic [5:0] b;
        n = (sz == BYTE) ? 1 : (sz == HALF) ? 2 : 4;
        for (int k = 0; k < n; k++) begin
            b = a + 6'(k);
            model[b[5:4]].bytes[b[3:0]] = d[8*k +: 8];
        end
    endtask

    // Every cycle starts as a non-memory op with random sideband
    task automatic begin_cycle();
        logic [31:0] r;
        @(negedge clk_i);
        r = rand_word();
        memop_rd_i       = 1'b0;
        memop_wr_i       = 1'b0;
        mmu_data_rdy_i   = 1'b0;
        memop_addr_i     = rand_word();
        memop_type_i     = WORD;
        memop_sign_ext_i = 1'b0;
        rf_we_i          = r[0];
        tkbr_i           = r[1];
        rf_waddr_i       = r[6:2];
        new_pc_i         = rand_word();
    endtask

    task automatic push_expected(input logic [31:0] res);
        exp_res_q.push_back(res);
        exp_we_q.push_back(rf_we_i);
        exp_waddr_q.push_back(rf_waddr_i);
        exp_tkbr_q.push_back(tkbr_i);
        exp_pc_q.push_back(new_pc_i);
    endtask

    task automatic idle_op();
        begin_cycle();
        push_expected(memop_addr_i);
    endtask

    task automatic fill_lane(input logic [1:0] idx);
        dcache_lane_u lane;
        begin_cycle();
        for (int w = 0; w < LANE_WORDS; w++) begin
            lane.words[w] = rand_word();
        end
        model[idx]      = lane;
        mmu_data_rdy_i  = 1'b1;
        mmu_data_i      = lane;
        mmu_lru_index_i = idx;
        push_expected(memop_addr_i);
    endtask

    task automatic load_op(input logic [5:0] a, input memop_size_e sz, input logic sext);
        begin_cycle();
        memop_rd_i       = 1'b1;
        memop_addr_i     = {26'd0, a};
        memop_type_i     = sz;
        memop_sign_ext_i = sext;
        push_expected(expected_load(a, sz, sext));
    endtask

    task automatic store_op(input logic [5:0] a, input memop_size_e sz, input logic [31:0] d);
        begin_cycle();
        memop_wr_i   = 1'b1;
        memop_addr_i = {26'd0, a};
        memop_type_i = sz;
        store_data_i = d;
        model_store(a, sz, d);
        push_expected(memop_addr_i);
    endtask

    // Aligned store of random size, optionally read straight back
    task automatic random_store(input logic load_back);
        logic [31:0] r;
        memop_size_e sz;
        logic [5:0]  a;
        r  = rand_word();
        sz = (r[1:0] == 2'd0) ? BYTE : (r[1:0] == 2'd1) ? HALF : WORD;
        a  = r[13:8];
        if (sz == HALF) begin
            a[0] = 1'b0;
        end
        if (sz == WORD) begin
            a[1:0] = 2'b00;
        end
        store_op(a, sz, rand_word());
        if (load_back) begin
            load_op(a, sz, r[31]);
        end
    endtask

    // Entered right after stores, so the first idle cycle still sees pending entries
    task automatic wait_sb_empty();
        int cycles;
        cycles = 0;
        do begin
            idle_op();
            if (cycles == 0 && sb_empty_o !== 1'b0) begin
                $display("MISMATCH sb_empty_o with stores pending: got %h expected %h",
                         sb_empty_o, 1'b0);
                errors++;
            end
            cycles++;
        end while (!sb_empty_o && cycles < DRAIN_LIMIT);
        if (!sb_empty_o) begin
            $display("ERROR: store buffer still not empty after %0d idle cycles", cycles);
            errors++;
        end
    endtask

    task automatic check_reset_state();
        checks++;
        if (rf_we_o !== 1'b0) begin
            $display("MISMATCH rf_we_o after reset: got %h expected %h", rf_we_o, 1'b0);
            errors++;
        end
        if (tkbr_o !== 1'b0) begin
            $display("MISMATCH tkbr_o after reset: got %h expected %h", tkbr_o, 1'b0);
            errors++;
        end
        if (sb_empty_o !== 1'b1) begin
            $display("MISMATCH sb_empty_o after reset: got %h expected %h", sb_empty_o, 1'b1);
            errors++;
        end
        if (op_res_o !== 32'h0) begin
            $display("MISMATCH op_res_o after reset: got %h expected %h", op_res_o, 32'h0);
            errors++;
        end
        if (new_pc_o !== 32'h0) begin
            $display("MISMATCH new_pc_o after reset: got %h expected %h", new_pc_o, 32'h0);
            errors++;
        end
    endtask

    // Outputs settle just after the rising edge
    initial begin : compare_outputs
        logic [`WORD_SIZE-1:0] e_res;
        logic                  e_we;
        logic [`REG_SIZE-1:0]  e_waddr;
        logic                  e_tkbr;
        logic [`WORD_SIZE-1:0] e_pc;
        forever begin
            @(posedge clk_i);
            #1;
            if (exp_res_q.size() != 0) begin
                e_res   = exp_res_q.pop_front();
                e_we    = exp_we_q.pop_front();
                e_waddr = exp_waddr_q.pop_front();
                e_tkbr  = exp_tkbr_q.pop_front();
                e_pc    = exp_pc_q.pop_front();
                checks++;
                if (op_res_o !== e_res) begin
                    $display("MISMATCH op_res_o: got %h expected %h", op_res_o, e_res);
                    errors++;
                end
                if (rf_we_o !== e_we) begin
                    $display("MISMATCH rf_we_o: got %h expected %h", rf_we_o, e_we);
                    errors++;
                end
                if (rf_waddr_o !== e_waddr) begin
                    $display("MISMATCH rf_waddr_o: got %h expected %h", rf_waddr_o, e_waddr);
                    errors++;
                end
                if (tkbr_o !== e_tkbr) begin
                    $display("MISMATCH tkbr_o: got %h expected %h", tkbr_o, e_tkbr);
                    errors++;
                end
                if (new_pc_o !== e_pc) begin
                    $display("MISMATCH new_pc_o: got %h expected %h", new_pc_o, e_pc);
                    errors++;
                end
            end
        end
    end

    initial begin : stimulus
        int k;
        rng_state        = 32'hc1ac30fe;
        errors           = 0;
        checks           = 0;
        arst_n_i         = 1'b0;
        memop_rd_i       = 1'b0;
        memop_wr_i       = 1'b0;
        memop_addr_i     = '1;
        memop_type_i     = WORD;
        memop_sign_ext_i = 1'b0;
        store_data_i     = '0;
        rf_we_i          = 1'b1;
        rf_waddr_i       = '1;
        tkbr_i           = 1'b1;
        new_pc_i         = '1;
        mmu_data_rdy_i   = 1'b0;
        mmu_data_i       = '0;
        mmu_lru_index_i  = '0;
        repeat (5) @(negedge clk_i);
        arst_n_i = 1'b1;
        check_reset_state();

        for (int i = 0; i < `DCACHE_LINES; i++) begin
            fill_lane(2'(i));
        end
        for (int i = 0; i < 16; i++) begin
            load_op(6'(i * 4), WORD, 1'b0);
        end

        // Narrow loads at every aligned offset
        for (int i = 0; i < 64; i++) begin
            load_op(6'(i), BYTE, 1'b0);
            load_op(6'(i), BYTE, 1'b1);
            if (i % 2 == 0) begin
                load_op(6'(i), HALF, 1'b0);
                load_op(6'(i), HALF, 1'b1);
            end
        end

        for (int i = 0; i < 20; i++) begin
            idle_op();
        end

        // Forwarding from the store buffer
        for (int i = 0; i < 12; i++) begin
            random_store(1'b1);
        end
        wait_sb_empty();

        for (int i = 0; i < `SB_ENTRIES + 3; i++) begin
            random_store(1'b0);
        end
        wait_sb_empty();
        for (int i = 0; i < 16; i++) begin
            load_op(6'(i * 4), WORD, 1'b0);
        end

        k = 0;
        while (exp_res_q.size() != 0 && k < 8) begin
            @(negedge clk_i);
            k++;
        end
        if (exp_res_q.size() != 0) begin
            $display("ERROR: %0d expected results were never compared", exp_res_q.size());
            errors++;
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* mem_subsystem.f */
+incdir+design
design/mem_sub_pkg.sv
design/dcache_data.sv
design/store_buffer.sv
design/mem_stage.sv
design/mem_subsystem_top.sv
verification/mem_subsystem_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
SIM_BIN=mem_subsystem_sim

verilator --binary --timing --assert -Wno-fatal \
    -f mem_subsystem.f --top-module mem_subsystem_tb \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "=== PASS ===" "$LOG_FILE"; then
    exit 0
fi
exit 1
